// ==== vlog.f ====
common/mini_mcu_pkg.sv
design/system_bus/bus_arbiter.sv
design/system_bus/bus_decoder.sv
design/memory/ram_banks.sv
design/ao_peripheral/ao_peripheral_regs.sv
design/ao_peripheral/dma_engine.sv
design/core_v_mini_mcu.sv
sim/tb_core_v_mini_mcu.sv

// ==== Bender.yml ====
package:
  name: core_v_mini_mcu

sources:
  - common/mini_mcu_pkg.sv
  - design/system_bus/bus_arbiter.sv
  - design/system_bus/bus_decoder.sv
  - design/memory/ram_banks.sv
  - design/ao_peripheral/ao_peripheral_regs.sv
  - design/ao_peripheral/dma_engine.sv
  - design/core_v_mini_mcu.sv
  - target: simulation
    files:
      - sim/tb_core_v_mini_mcu.sv

// ==== sim/tb_core_v_mini_mcu.sv ====
// ***************************************************************************
// mini MCU testbench with directed host-port tests of RAM, error responses,
// DMA copy with and without contention and the exit register
// ***************************************************************************

`timescale 1ns/1ps

module tb_core_v_mini_mcu
  import mini_mcu_pkg::*;
();

  localparam int NUM_BANKS  = 2;
  localparam int BANK_WORDS = 256;
  localparam int RAM_WORDS  = NUM_BANKS * BANK_WORDS;
  localparam int GNT_LIMIT  = 16;
  localparam int POLL_LIMIT = 200;

  // per-test cycle budgets summed for the watchdog
  localparam int BUDGET_RESET   = 40;
  localparam int BUDGET_RAM     = 400;
  localparam int BUDGET_UNMAP   = 60;
  localparam int BUDGET_DMA     = 1200;
  localparam int BUDGET_CONTEND = 1200;
  localparam int BUDGET_EXIT    = 40;
  localparam int BUDGET_MARGIN  = 500;
  localparam int BUDGET_TOTAL   = BUDGET_RESET + BUDGET_RAM + BUDGET_UNMAP + BUDGET_DMA +
                                  BUDGET_CONTEND + BUDGET_EXIT + BUDGET_MARGIN;

  logic        clk;
  logic        rst;
  obi_req_t    host_req;
  obi_resp_t   host_resp;
  logic        irq;
  logic [31:0] exit_value;
  logic        exit_valid;

  // mirror of the RAM contents written so far
  logic [31:0] ref_mem [RAM_WORDS];
  logic [31:0] lcg_state;
  logic [31:0] last_rdata;
  int          last_grant_wait;
  int          errors;
  int          checks;

  core_v_mini_mcu #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) core_v_mini_mcu_inst (
    .clk_i          (clk),
    .rst_i          (rst),
    .ext_host_req_i (host_req),
    .ext_host_resp_o(host_resp),
    .irq_o          (irq),
    .exit_value_o   (exit_value),
    .exit_valid_o   (exit_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [11:0] offset);
    return AO_PERIPH_BASE + 32'(offset);
  endfunction

  task automatic report_failure(input string msg);
    errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_grant_latency();
    checks++;
    assert (last_grant_wait <= 1) else begin
      report_failure($sformatf("host request waited %0d cycles for gnt", last_grant_wait));
    end
  endtask

  // hold req until gnt and then take the data phase
  task automatic issue_request(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] be,
                               output logic [31:0] rdata, output logic err);
    int   waited;
    logic granted;
    waited = 0;
    rdata  = '0;
    err    = 1'b1;
    @(posedge clk);
    host_req.req   <= 1'b1;
    host_req.we    <= we;
    host_req.be    <= be;
    host_req.addr  <= addr;
    host_req.wdata <= wdata;
    @(negedge clk);
    while (!host_resp.gnt && (waited < GNT_LIMIT)) begin
      waited++;
      @(negedge clk);
    end
    granted         = host_resp.gnt;
    last_grant_wait = waited;
    @(posedge clk);
    host_req <= '0;
    checks++;
    assert (granted) else begin
      report_failure($sformatf("host request to 0x%08h was never granted", addr));
    end
    if (granted) begin
      @(negedge clk);
      checks++;
      assert (host_resp.rvalid) else begin
        report_failure($sformatf("no rvalid in the cycle after gnt for 0x%08h", addr));
      end
      rdata = host_resp.rdata;
      err   = host_resp.err;
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be, output logic err);
    issue_request(1'b1, addr, data, be, last_rdata, err);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic err);
    issue_request(1'b0, addr, '0, 4'hF, data, err);
  endtask

  task automatic write_ram_word(input int idx, input logic [31:0] data, input logic [3:0] be);
    logic err;
    bus_write(RAM_BASE + 32'(idx * 4), data, be, err);
    check_eq("ext_host_resp_o.err", 32'(err), 32'h0);
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        ref_mem[idx][i*8 +: 8] = data[i*8 +: 8];
      end
    end
  endtask

  task automatic verify_ram_word(input int idx);
    logic [31:0] data;
    logic        err;
    bus_read(RAM_BASE + 32'(idx * 4), data, err);
    check_eq($sformatf("ext_host_resp_o.rdata[word %0d]", idx), data, ref_mem[idx]);
    check_eq("ext_host_resp_o.err", 32'(err), 32'h0);
  endtask

  task automatic fill_words(input int base, input int n);
    for (int i = 0; i < n; i++) begin
      write_ram_word(base + i, lcg_next(), 4'hF);
    end
  endtask

  task automatic start_dma(input int src_word, input int dst_word, input int len);
    logic err;
    logic err_any;
    bus_write(reg_addr(DMA_SRC_OFFSET), RAM_BASE + 32'(src_word * 4), 4'hF, err);
    err_any = err;
    bus_write(reg_addr(DMA_DST_OFFSET), RAM_BASE + 32'(dst_word * 4), 4'hF, err);
    err_any |= err;
    bus_write(reg_addr(DMA_LEN_OFFSET), 32'(len), 4'hF, err);
    err_any |= err;
    check_eq("ext_host_resp_o.err", 32'(err_any), 32'h0);
  endtask

  task automatic wait_dma_done();
    logic [31:0] status;
    logic        err;
    int          polls;
    status = '0;
    polls  = 0;
    while (!status[1] && (polls < POLL_LIMIT)) begin
      bus_read(reg_addr(DMA_STATUS_OFFSET), status, err);
      polls++;
    end
    checks++;
    assert (status[1]) else begin
      report_failure("DMA copy never reported done in the status register");
    end
    if (status[1]) begin
      // done with busy already low
      check_eq("dma status", status, 32'h2);
    end
  endtask

  task automatic check_copy(input int src_word, input int dst_word, input int len);
    for (int i = 0; i < len; i++) begin
      ref_mem[dst_word + i] = ref_mem[src_word + i];
      verify_ram_word(dst_word + i);
    end
  endtask

  task automatic clear_done();
    logic [31:0] status;
    logic        err;
    bus_write(reg_addr(DMA_STATUS_OFFSET), 32'h2, 4'hF, err);
    bus_read(reg_addr(DMA_STATUS_OFFSET), status, err);
    check_eq("dma status", status, 32'h0);
    @(negedge clk);
    check_eq("irq_o", 32'(irq), 32'h0);
  endtask

  task automatic test_reset_state();
    logic [31:0] status;
    logic        err;
    @(negedge clk);
    check_eq("ext_host_resp_o.gnt", 32'(host_resp.gnt), 32'h0);
    check_eq("ext_host_resp_o.rvalid", 32'(host_resp.rvalid), 32'h0);
    check_eq("irq_o", 32'(irq), 32'h0);
    check_eq("exit_valid_o", 32'(exit_valid), 32'h0);
    bus_read(reg_addr(DMA_STATUS_OFFSET), status, err);
    check_eq("dma status", status, 32'h0);
    check_eq("ext_host_resp_o.err", 32'(err), 32'h0);
  endtask

  task automatic test_ram_access();
    int          idx_list[$];
    int          idx;
    logic [31:0] rnd;
    logic [3:0]  be;
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int n = 0; n < 12; n++) begin
        idx = b * BANK_WORDS + int'(lcg_next() % BANK_WORDS);
        write_ram_word(idx, lcg_next(), 4'hF);
        idx_list.push_back(idx);
      end
    end
    // partial byte writes over words that already hold data
    foreach (idx_list[k]) begin
      if (k % 3 == 0) begin
        rnd = lcg_next();
        be  = rnd[3:0];
        if ((be == 4'h0) || (be == 4'hF)) begin
          be = 4'h6;
        end
        write_ram_word(idx_list[k], lcg_next(), be);
      end
    end
    foreach (idx_list[k]) begin
      verify_ram_word(idx_list[k]);
    end
  endtask

  task automatic test_unmapped();
    logic [31:0] data;
    logic        err;
    write_ram_word(0, lcg_next(), 4'hF);
    write_ram_word(RAM_WORDS - 1, lcg_next(), 4'hF);
    // just past the RAM and aliasing word 0 if decoded as RAM
    bus_write(RAM_BASE + 32'(RAM_WORDS * 4), lcg_next(), 4'hF, err);
    check_eq("ext_host_resp_o.err", 32'(err), 32'h1);
    check_eq("ext_host_resp_o.rdata", last_rdata, 32'h0);
    bus_read(32'h4000_0000, data, err);
    check_eq("ext_host_resp_o.err", 32'(err), 32'h1);
    check_eq("ext_host_resp_o.rdata", data, 32'h0);
    bus_read(AO_PERIPH_BASE + AO_PERIPH_SIZE, data, err);
    check_eq("ext_host_resp_o.err", 32'(err), 32'h1);
    check_eq("ext_host_resp_o.rdata", data, 32'h0);
    verify_ram_word(0);
    verify_ram_word(RAM_WORDS - 1);
  endtask

  task automatic test_dma_copy();
    logic err;
    fill_words(64, 40);
    bus_write(reg_addr(IRQ_ENABLE_OFFSET), 32'h1, 4'hF, err);
    check_eq("ext_host_resp_o.err", 32'(err), 32'h0);
    start_dma(64, 320, 40);
    wait_dma_done();
    @(negedge clk);
    check_eq("irq_o", 32'(irq), 32'h1);
    check_copy(64, 320, 40);
    clear_done();
  endtask

  task automatic test_contention();
    fill_words(128, 32);
    start_dma(128, 400, 32);
    // host traffic on words 200.. and 460.. away from the copy
    for (int i = 0; i < 12; i++) begin
      write_ram_word(200 + i, lcg_next(), 4'hF);
      check_grant_latency();
      write_ram_word(460 + i, lcg_next(), 4'hF);
      check_grant_latency();
    end
    for (int i = 0; i < 12; i++) begin
      verify_ram_word(200 + i);
      check_grant_latency();
      verify_ram_word(460 + i);
      check_grant_latency();
    end
    wait_dma_done();
    check_copy(128, 400, 32);
    clear_done();
  endtask

  task automatic test_exit_value();
    logic [31:0] value;
    logic        err;
    value = lcg_next();
    check_eq("exit_valid_o", 32'(exit_valid), 32'h0);
    bus_write(reg_addr(EXIT_VALUE_OFFSET), value, 4'hF, err);
    check_eq("ext_host_resp_o.err", 32'(err), 32'h0);
    @(posedge clk);
    @(negedge clk);
    check_eq("exit_valid_o", 32'(exit_valid), 32'h1);
    check_eq("exit_value_o", exit_value, value);
  endtask

  initial begin
    errors    = 0;
    checks    = 0;
    lcg_state = 32'h0e93787a;
    rst       = 1'b1;
    host_req  = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    test_reset_state();
    test_ram_access();
    test_unmapped();
    test_dma_copy();
    test_contention();
    test_exit_value();

    $display("tests done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (BUDGET_TOTAL) @(posedge clk);
    $display("ERROR: run did not finish within %0d cycles", BUDGET_TOTAL);
    $display("tests done: %0d checks, %0d errors", checks, errors + 1);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== design/core_v_mini_mcu.sv ====
// ***************************************************************************
// mini MCU top: host port and DMA share one system bus to banked RAM
// and the always-on peripheral registers
// ***************************************************************************

`timescale 1ns/1ps

module core_v_mini_mcu
  import mini_mcu_pkg::*;
#(
  parameter int NUM_BANKS  = 2,
  parameter int BANK_WORDS = 256
) (
  input  logic              clk_i,
  input  logic              rst_i,

  input  obi_req_t          ext_host_req_i,
  output obi_resp_t         ext_host_resp_o,

  output logic              irq_o,
  output logic [DATA_W-1:0] exit_value_o,
  output logic              exit_valid_o
);

  // masters
  obi_req_t          dma_req;
  obi_resp_t         dma_resp;

  // shared bus and targets
  obi_req_t          bus_req;
  obi_resp_t         bus_resp;
  obi_req_t          ram_req;
  logic [DATA_W-1:0] ram_rdata;
  obi_req_t          periph_req;
  logic [DATA_W-1:0] periph_rdata;

  // dma control
  dma_cfg_t          dma_cfg;
  logic              dma_busy;
  logic              dma_done;

  bus_arbiter bus_arbiter_inst (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .host_req_i (ext_host_req_i),
    .host_resp_o(ext_host_resp_o),
    .dma_req_i  (dma_req),
    .dma_resp_o (dma_resp),
    .bus_req_o  (bus_req),
    .bus_resp_i (bus_resp)
  );

  bus_decoder #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) bus_decoder_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .bus_req_i     (bus_req),
    .bus_resp_o    (bus_resp),
    .ram_req_o     (ram_req),
    .ram_rdata_i   (ram_rdata),
    .periph_req_o  (periph_req),
    .periph_rdata_i(periph_rdata)
  );

  ram_banks #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) ram_banks_inst (
    .clk_i  (clk_i),
    .req_i  (ram_req),
    .rdata_o(ram_rdata)
  );

  ao_peripheral_regs ao_peripheral_regs_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (periph_req),
    .rdata_o     (periph_rdata),
    .dma_cfg_o   (dma_cfg),
    .dma_busy_i  (dma_busy),
    .dma_done_i  (dma_done),
    .irq_o       (irq_o),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

  dma_engine dma_engine_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cfg_i        (dma_cfg),
    .master_req_o (dma_req),
    .master_resp_i(dma_resp),
    .busy_o       (dma_busy),
    .done_o       (dma_done)
  );

endmodule

// ==== design/ao_peripheral/dma_engine.sv ====
// ***************************************************************************
// word-copy DMA engine: bus master moving len words from src to dst
// ***************************************************************************

`timescale 1ns/1ps

module dma_engine
  import mini_mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,

  input  dma_cfg_t  cfg_i,

  output obi_req_t  master_req_o,
  input  obi_resp_t master_resp_i,

  output logic      busy_o,
  output logic      done_o
);

  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_RD_REQ  = 3'd1;
  localparam logic [2:0] ST_RD_WAIT = 3'd2;
  localparam logic [2:0] ST_WR_REQ  = 3'd3;
  localparam logic [2:0] ST_WR_WAIT = 3'd4;

  logic [2:0]        state_q;
  logic              done_q;
  logic [ADDR_W-1:0] src_ptr_q;
  logic [ADDR_W-1:0] dst_ptr_q;
  logic [15:0]       count_q;
  logic [DATA_W-1:0] data_q;

  // control FSM, an error response aborts the copy
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (cfg_i.start) begin
            if (cfg_i.len == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= ST_RD_REQ;
            end
          end
        end
        ST_RD_REQ: if (master_resp_i.gnt) state_q <= ST_RD_WAIT;
        ST_RD_WAIT: begin
          if (master_resp_i.rvalid) begin
            if (master_resp_i.err) begin
              state_q <= ST_IDLE;
              done_q  <= 1'b1;
            end else begin
              state_q <= ST_WR_REQ;
            end
          end
        end
        ST_WR_REQ: if (master_resp_i.gnt) state_q <= ST_WR_WAIT;
        ST_WR_WAIT: begin
          if (master_resp_i.rvalid) begin
            if (master_resp_i.err || (count_q == 16'd1)) begin
              state_q <= ST_IDLE;
              done_q  <= 1'b1;
            end else begin
              state_q <= ST_RD_REQ;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // pointers, word count and the word in flight
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_IDLE) && cfg_i.start) begin
      src_ptr_q <= cfg_i.src;
      dst_ptr_q <= cfg_i.dst;
      count_q   <= cfg_i.len;
    end
    if ((state_q == ST_RD_WAIT) && master_resp_i.rvalid) begin
      data_q <= master_resp_i.rdata;
    end
    if ((state_q == ST_WR_WAIT) && master_resp_i.rvalid) begin
      src_ptr_q <= src_ptr_q + ADDR_W'(4);
      dst_ptr_q <= dst_ptr_q + ADDR_W'(4);
      count_q   <= count_q - 16'd1;
    end
  end

  always_comb begin
    master_req_o    = '0;
    master_req_o.be = 4'hF;
    if (state_q == ST_RD_REQ) begin
      master_req_o.req  = 1'b1;
      master_req_o.addr = src_ptr_q;
    end else if (state_q == ST_WR_REQ) begin
      master_req_o.req   = 1'b1;
      master_req_o.we    = 1'b1;
      master_req_o.addr  = dst_ptr_q;
      master_req_o.wdata = data_q;
    end
  end

  assign busy_o = (state_q != ST_IDLE);
  assign done_o = done_q;

endmodule

// ==== design/ao_peripheral/ao_peripheral_regs.sv ====
// ***************************************************************************
// always-on peripheral registers: DMA setup and status, interrupt
// enable, and the exit value/valid pair
// ***************************************************************************

`timescale 1ns/1ps

module ao_peripheral_regs
  import mini_mcu_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,

  input  obi_req_t          req_i,
  output logic [DATA_W-1:0] rdata_o,

  output dma_cfg_t          dma_cfg_o,
  input  logic              dma_busy_i,
  input  logic              dma_done_i,

  output logic              irq_o,
  output logic [DATA_W-1:0] exit_value_o,
  output logic              exit_valid_o
);

  logic [11:0]       offset;
  logic              wr_en;
  logic [DATA_W-1:0] rdata_d;
  logic [DATA_W-1:0] rdata_q;
  logic [ADDR_W-1:0] src_q;
  logic [ADDR_W-1:0] dst_q;
  logic [15:0]       len_q;
  logic [DATA_W-1:0] exit_value_q;
  logic              start_q;
  logic              irq_en_q;
  logic              done_q;
  logic              irq_q;
  logic              exit_valid_q;

  function automatic logic [DATA_W-1:0] merge_be(input logic [DATA_W-1:0] old_val,
                                                 input logic [DATA_W-1:0] new_val,
                                                 input logic [3:0]        be);
    logic [DATA_W-1:0] merged;
    merged = old_val;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        merged[i*8 +: 8] = new_val[i*8 +: 8];
      end
    end
    return merged;
  endfunction

  assign offset = req_i.addr[11:0];
  assign wr_en  = req_i.req & req_i.we;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      start_q      <= 1'b0;
      irq_en_q     <= 1'b0;
      done_q       <= 1'b0;
      irq_q        <= 1'b0;
      exit_valid_q <= 1'b0;
    end else begin
      start_q <= wr_en && (offset == DMA_LEN_OFFSET);
      if (wr_en && (offset == IRQ_ENABLE_OFFSET)) begin
        irq_en_q <= req_i.wdata[0];
      end
      // a completion in the same cycle as the clear wins
      if (dma_done_i) begin
        done_q <= 1'b1;
      end else if (wr_en && (offset == DMA_STATUS_OFFSET)) begin
        done_q <= 1'b0;
      end
      irq_q <= done_q & irq_en_q;
      if (wr_en && (offset == EXIT_VALUE_OFFSET)) begin
        exit_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en && (offset == DMA_SRC_OFFSET)) src_q <= merge_be(src_q, req_i.wdata, req_i.be);
    if (wr_en && (offset == DMA_DST_OFFSET)) dst_q <= merge_be(dst_q, req_i.wdata, req_i.be);
    if (wr_en && (offset == DMA_LEN_OFFSET)) len_q <= req_i.wdata[15:0];
    if (wr_en && (offset == EXIT_VALUE_OFFSET)) begin
      exit_value_q <= merge_be(exit_value_q, req_i.wdata, req_i.be);
    end
    if (req_i.req) rdata_q <= rdata_d;
  end

  always_comb begin
    case (offset)
      DMA_SRC_OFFSET:    rdata_d = src_q;
      DMA_DST_OFFSET:    rdata_d = dst_q;
      DMA_LEN_OFFSET:    rdata_d = {16'h0, len_q};
      DMA_STATUS_OFFSET: rdata_d = {30'h0, done_q, dma_busy_i};
      IRQ_ENABLE_OFFSET: rdata_d = {31'h0, irq_en_q};
      EXIT_VALUE_OFFSET: rdata_d = exit_value_q;
      default:           rdata_d = '0;
    endcase
  end

  assign dma_cfg_o.src   = src_q;
  assign dma_cfg_o.dst   = dst_q;
  assign dma_cfg_o.len   = len_q;
  assign dma_cfg_o.start = start_q;

  assign rdata_o      = rdata_q;
  assign irq_o        = irq_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

endmodule

// ==== design/memory/ram_banks.sv ====
// ***************************************************************************
// banked on-chip RAM: single-port word banks with byte enables
// ***************************************************************************

`timescale 1ns/1ps

module ram_banks
  import mini_mcu_pkg::*;
#(
  parameter int NUM_BANKS  = 2,
  parameter int BANK_WORDS = 256
) (
  input  logic              clk_i,
  input  obi_req_t          req_i,
  output logic [DATA_W-1:0] rdata_o
);

  localparam int WORD_AW = $clog2(BANK_WORDS);
  localparam int SEL_W   = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  logic [WORD_AW-1:0] word_idx;
  logic [SEL_W-1:0]   bank_sel;
  logic [SEL_W-1:0]   bank_q;
  logic [DATA_W-1:0]  bank_rdata [NUM_BANKS];

  // bank from the upper word-index bits
  assign word_idx = req_i.addr[2 +: WORD_AW];
  assign bank_sel = req_i.addr[2 + WORD_AW +: SEL_W];

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    logic [DATA_W-1:0] mem [BANK_WORDS];

    always_ff @(posedge clk_i) begin
      if (req_i.req && (bank_sel == SEL_W'(b))) begin
        if (req_i.we) begin
          for (int i = 0; i < 4; i++) begin
            if (req_i.be[i]) begin
              mem[word_idx][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
            end
          end
        end
        bank_rdata[b] <= mem[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      bank_q <= bank_sel;
    end
  end

  assign rdata_o = bank_rdata[bank_q];

endmodule

// ==== design/system_bus/bus_decoder.sv ====
// ***************************************************************************
// system bus decoder: routes granted requests to RAM or peripherals,
// answers unmapped addresses with an error and muxes read data back
// ***************************************************************************

`timescale 1ns/1ps

module bus_decoder
  import mini_mcu_pkg::*;
#(
  parameter int NUM_BANKS  = 2,
  parameter int BANK_WORDS = 256
) (
  input  logic              clk_i,
  input  logic              rst_i,

  input  obi_req_t          bus_req_i,
  output obi_resp_t         bus_resp_o,

  output obi_req_t          ram_req_o,
  input  logic [DATA_W-1:0] ram_rdata_i,

  output obi_req_t          periph_req_o,
  input  logic [DATA_W-1:0] periph_rdata_i
);

  localparam logic [ADDR_W-1:0] RAM_SIZE = ADDR_W'(NUM_BANKS * BANK_WORDS * 4);

  localparam logic [1:0] REGION_NONE   = 2'd0;
  localparam logic [1:0] REGION_RAM    = 2'd1;
  localparam logic [1:0] REGION_PERIPH = 2'd2;

  logic [ADDR_W-1:0] ram_off;
  logic [ADDR_W-1:0] periph_off;
  logic              ram_hit;
  logic              periph_hit;
  logic [1:0]        region_d;
  logic [1:0]        region_q;
  logic              rvalid_q;

  // offsets relative to each region base, unsigned compare covers both ends
  assign ram_off    = bus_req_i.addr - RAM_BASE;
  assign periph_off = bus_req_i.addr - AO_PERIPH_BASE;
  assign ram_hit    = ram_off < RAM_SIZE;
  assign periph_hit = periph_off < AO_PERIPH_SIZE;

  assign region_d = ram_hit    ? REGION_RAM    :
                    periph_hit ? REGION_PERIPH : REGION_NONE;

  always_comb begin
    ram_req_o         = bus_req_i;
    ram_req_o.req     = bus_req_i.req & ram_hit;
    ram_req_o.addr    = ram_off;
    periph_req_o      = bus_req_i;
    periph_req_o.req  = bus_req_i.req & periph_hit;
    periph_req_o.addr = periph_off;
  end

  // data phase bookkeeping
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
      region_q <= REGION_NONE;
    end else begin
      rvalid_q <= bus_req_i.req;
      if (bus_req_i.req) begin
        region_q <= region_d;
      end
    end
  end

  // targets are always ready
  assign bus_resp_o.gnt    = bus_req_i.req;
  assign bus_resp_o.rvalid = rvalid_q;
  assign bus_resp_o.err    = rvalid_q & (region_q == REGION_NONE);

  always_comb begin
    case (region_q)
      REGION_RAM:    bus_resp_o.rdata = ram_rdata_i;
      REGION_PERIPH: bus_resp_o.rdata = periph_rdata_i;
      default:       bus_resp_o.rdata = '0;
    endcase
  end

endmodule

// ==== design/system_bus/bus_arbiter.sv ====
// ***************************************************************************
// system bus arbiter: round-robin grant between host and DMA masters,
// data-phase responses steered back to the owning master
// ***************************************************************************

`timescale 1ns/1ps

module bus_arbiter
  import mini_mcu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,

  input  obi_req_t  host_req_i,
  output obi_resp_t host_resp_o,

  input  obi_req_t  dma_req_i,
  output obi_resp_t dma_resp_o,

  output obi_req_t  bus_req_o,
  input  obi_resp_t bus_resp_i
);

  logic sel;
  // last granted master, also owner of the following data phase
  logic owner_q;

  always_comb begin
    if (host_req_i.req && dma_req_i.req) begin
      sel = (owner_q == MASTER_HOST) ? MASTER_DMA : MASTER_HOST;
    end else if (dma_req_i.req) begin
      sel = MASTER_DMA;
    end else begin
      sel = MASTER_HOST;
    end
  end

  always_comb begin
    bus_req_o     = (sel == MASTER_DMA) ? dma_req_i : host_req_i;
    bus_req_o.req = host_req_i.req | dma_req_i.req;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      owner_q <= MASTER_DMA;
    end else if (bus_req_o.req && bus_resp_i.gnt) begin
      owner_q <= sel;
    end
  end

  always_comb begin
    host_resp_o.gnt    = bus_resp_i.gnt & host_req_i.req & (sel == MASTER_HOST);
    host_resp_o.rvalid = bus_resp_i.rvalid & (owner_q == MASTER_HOST);
    host_resp_o.rdata  = (owner_q == MASTER_HOST) ? bus_resp_i.rdata : '0;
    host_resp_o.err    = bus_resp_i.err & (owner_q == MASTER_HOST);

    dma_resp_o.gnt     = bus_resp_i.gnt & dma_req_i.req & (sel == MASTER_DMA);
    dma_resp_o.rvalid  = bus_resp_i.rvalid & (owner_q == MASTER_DMA);
    dma_resp_o.rdata   = (owner_q == MASTER_DMA) ? bus_resp_i.rdata : '0;
    dma_resp_o.err     = bus_resp_i.err & (owner_q == MASTER_DMA);
  end

endmodule

// ==== common/mini_mcu_pkg.sv ====
// ***************************************************************************
// mini MCU shared definitions: bus request/response structs, address map,
// peripheral register offsets and the DMA setup bundle
// ***************************************************************************

package mini_mcu_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // address map
  localparam logic [ADDR_W-1:0] RAM_BASE       = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] AO_PERIPH_BASE = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] AO_PERIPH_SIZE = 32'h0000_1000;

  // always-on peripheral register offsets
  localparam logic [11:0] DMA_SRC_OFFSET    = 12'h000;
  localparam logic [11:0] DMA_DST_OFFSET    = 12'h004;
  // a write here starts the copy
  localparam logic [11:0] DMA_LEN_OFFSET    = 12'h008;
  // bit0 busy, bit1 done
  localparam logic [11:0] DMA_STATUS_OFFSET = 12'h00C;
  localparam logic [11:0] IRQ_ENABLE_OFFSET = 12'h010;
  localparam logic [11:0] EXIT_VALUE_OFFSET = 12'h014;

  // master indices on the system bus
  localparam logic MASTER_HOST = 1'b0;
  localparam logic MASTER_DMA  = 1'b1;

  // request channel, fields held stable until gnt
  typedef struct packed {
    logic              req;
    logic              we;
    logic [3:0]        be;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } obi_req_t;

  // response channel, rvalid one cycle after gnt
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    logic              err;
  } obi_resp_t;

  // register block to DMA engine
  typedef struct packed {
    logic [ADDR_W-1:0] src;
    logic [ADDR_W-1:0] dst;
    logic [15:0]       len;
    logic              start;
  } dma_cfg_t;

endpackage
